//--- include/fetch_params.svh
// Fetch stage size macros for address, instruction, FIFO and cache geometry
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Program counter width in bits
`define FETCH_ADDR_WIDTH 32

// Instruction word width in bits
`define FETCH_INSN_WIDTH 32

// Number of entries in the fetched instruction FIFO
`define FETCH_FIFO_DEPTH 8

// Total instruction cache capacity in bytes
`define FETCH_IC_SIZE 1024

// Cache line size in bytes, eight instructions per line
`define FETCH_IC_LINE_SIZE 32

`endif

//--- hw/fetch_pkg.sv
// Package fetch_pkg with address, instruction, cache line, FIFO entry and fetch state types
`include "fetch_params.svh"

package fetch_pkg;

    typedef logic [`FETCH_ADDR_WIDTH-1:0] addr_t;

    typedef logic [`FETCH_INSN_WIDTH-1:0] insn_t;

    // Word k of a line holds the instruction at line base + 4k
    typedef logic [`FETCH_IC_LINE_SIZE*8-1:0] ic_line_t;

    // Payload of the instruction FIFO
    typedef struct packed {
        addr_t pc;
        insn_t insn;
    } fetch_entry_t;

    // FETCH_NEXT: keep fetching sequential PCs
    // FETCH_IFQ_ENQUEUE: send the missed line to the IFQ
    // FETCH_IFQ_STALL: wait for the line fill
    // FETCH_FIFO_STALL: wait for room in the instruction FIFO
    typedef enum logic [1:0] {
        FETCH_NEXT        = 2'b00,
        FETCH_IFQ_ENQUEUE = 2'b01,
        FETCH_IFQ_STALL   = 2'b10,
        FETCH_FIFO_STALL  = 2'b11
    } fetch_state_t;

endpackage

//--- hw/fetch_fsm.sv
// Module fetch_fsm, the fetch state machine with lookup tracking and PC control
module fetch_fsm (
    input  logic clk,
    input  logic i_rst_n,

    input  logic i_redirect,

    input  logic i_ic_hit,
    input  logic i_fifo_full,

    input  logic i_ifq_full,
    input  logic i_ifq_fill_en,

    output logic o_ic_lookup_en,
    output logic o_pc_advance,
    output logic o_pc_restart,
    output logic o_fifo_wr_en,
    output logic o_ifq_alloc_en
);

    import fetch_pkg::*;

    fetch_state_t state_r;
    fetch_state_t state_next;
    logic         lookup_valid_r;
    logic         state_is_next;
    logic         lookup_hit;
    logic         lookup_miss;
    logic         lookup_stall;

    assign state_is_next = (state_r == FETCH_NEXT);

    // Result of the lookup launched last cycle
    assign lookup_hit  = lookup_valid_r & state_is_next & i_ic_hit;
    assign lookup_miss = lookup_valid_r & state_is_next & ~i_ic_hit;

    // A miss or a hit with no FIFO room stops the pipeline
    assign lookup_stall = lookup_miss | (lookup_hit & i_fifo_full);

    always_comb begin
        state_next = state_r;

        case (state_r)
            FETCH_NEXT: begin
                if (lookup_miss) begin
                    state_next = FETCH_IFQ_ENQUEUE;
                end else if (lookup_hit && i_fifo_full) begin
                    state_next = FETCH_FIFO_STALL;
                end
            end
            FETCH_IFQ_ENQUEUE: begin
                if (!i_ifq_full) begin
                    state_next = FETCH_IFQ_STALL;
                end
            end
            FETCH_IFQ_STALL: begin
                if (i_ifq_fill_en) begin
                    state_next = i_fifo_full ? FETCH_FIFO_STALL : FETCH_NEXT;
                end
            end
            FETCH_FIFO_STALL: begin
                if (!i_fifo_full) begin
                    state_next = FETCH_NEXT;
                end
            end
            default: begin
                state_next = FETCH_NEXT;
            end
        endcase

        // Redirect overrides everything
        if (i_redirect) begin
            state_next = FETCH_NEXT;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_r        <= FETCH_NEXT;
            lookup_valid_r <= 1'b0;
        end else begin
            state_r        <= state_next;
            lookup_valid_r <= o_ic_lookup_en;
        end
    end

    // New lookups only while streaming and not stopping this cycle
    assign o_ic_lookup_en = state_is_next & ~lookup_stall & ~i_redirect;
    assign o_pc_advance   = state_is_next & ~lookup_stall;

    // Reload the saved PC when leaving a stall
    assign o_pc_restart = ~state_is_next & (state_next == FETCH_NEXT) & ~i_redirect;

    assign o_fifo_wr_en = lookup_hit & ~i_fifo_full & ~i_redirect;

    // One request per miss, the cycle the IFQ has room
    assign o_ifq_alloc_en = (state_r == FETCH_IFQ_ENQUEUE) & ~i_ifq_full & ~i_redirect;

endmodule

//--- hw/fetch_pc.sv
// Module fetch_pc, the program counter with lookup-stage and restart address registers
`include "fetch_params.svh"

module fetch_pc (
    input  logic             clk,
    input  logic             i_rst_n,

    input  logic             i_redirect,
    input  fetch_pkg::addr_t i_redirect_addr,

    input  logic             i_advance,
    input  logic             i_restart,
    input  logic             i_lookup_en,

    output fetch_pkg::addr_t o_pc,
    output fetch_pkg::addr_t o_lookup_pc
);

    import fetch_pkg::*;

    localparam addr_t PC_STEP = addr_t'(`FETCH_INSN_WIDTH / 8);

    addr_t pc_r;
    addr_t lookup_pc_r;
    addr_t restart_pc_r;
    logic  lookup_pending_r;

    // Redirect beats restart, restart beats increment
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            pc_r             <= '0;
            lookup_pending_r <= 1'b0;
        end else begin
            lookup_pending_r <= i_lookup_en;
            if (i_redirect) begin
                pc_r <= i_redirect_addr;
            end else if (i_restart) begin
                pc_r <= restart_pc_r;
            end else if (i_advance) begin
                pc_r <= pc_r + PC_STEP;
            end
        end
    end

    // Address of the lookup in flight, held while fetch is stopped
    always_ff @(posedge clk) begin
        if (i_lookup_en) begin
            lookup_pc_r <= pc_r;
        end
        // Lookup resolving this cycle is the restart target
        if (lookup_pending_r) begin
            restart_pc_r <= lookup_pc_r;
        end
    end

    assign o_pc        = pc_r;
    assign o_lookup_pc = lookup_pc_r;

endmodule

//--- hw/fetch_icache.sv
// Module fetch_icache, a direct-mapped instruction cache with registered lookup and line fill
`include "fetch_params.svh"

module fetch_icache (
    input  logic                clk,
    input  logic                i_rst_n,

    input  logic                i_lookup_en,
    input  fetch_pkg::addr_t    i_lookup_addr,

    input  logic                i_fill_en,
    input  fetch_pkg::addr_t    i_fill_addr,
    input  fetch_pkg::ic_line_t i_fill_data,

    output logic                o_hit,
    output fetch_pkg::insn_t    o_data
);

    import fetch_pkg::*;

    localparam int LINE_COUNT = `FETCH_IC_SIZE / `FETCH_IC_LINE_SIZE;
    localparam int OFFSET_W   = $clog2(`FETCH_IC_LINE_SIZE);
    localparam int INDEX_W    = $clog2(LINE_COUNT);
    localparam int TAG_W      = `FETCH_ADDR_WIDTH - INDEX_W - OFFSET_W;
    localparam int WORD_LSB   = $clog2(`FETCH_INSN_WIDTH / 8);
    localparam int WORD_W     = OFFSET_W - WORD_LSB;

    ic_line_t              data_mem [LINE_COUNT];
    logic [TAG_W-1:0]      tag_mem  [LINE_COUNT];
    logic [LINE_COUNT-1:0] valid_r;

    logic [INDEX_W-1:0]    lookup_index;
    logic [TAG_W-1:0]      lookup_tag;
    logic [WORD_W-1:0]     lookup_word;
    logic [INDEX_W-1:0]    fill_index;
    logic [TAG_W-1:0]      fill_tag;
    logic                  lookup_match;
    logic                  fill_conflict;
    insn_t                 lookup_word_data;

    logic                  hit_r;
    insn_t                 data_r;

    // Address split: tag | index | word | byte
    assign lookup_index = i_lookup_addr[OFFSET_W +: INDEX_W];
    assign lookup_tag   = i_lookup_addr[OFFSET_W+INDEX_W +: TAG_W];
    assign lookup_word  = i_lookup_addr[WORD_LSB +: WORD_W];
    assign fill_index   = i_fill_addr[OFFSET_W +: INDEX_W];
    assign fill_tag     = i_fill_addr[OFFSET_W+INDEX_W +: TAG_W];

    assign lookup_match = valid_r[lookup_index] & (tag_mem[lookup_index] == lookup_tag);

    // Line being written this cycle cannot be read yet
    assign fill_conflict = i_fill_en & (fill_index == lookup_index);

    assign lookup_word_data =
        data_mem[lookup_index][lookup_word*`FETCH_INSN_WIDTH +: `FETCH_INSN_WIDTH];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            valid_r <= '0;
        end else if (i_fill_en) begin
            valid_r[fill_index] <= 1'b1;
        end
    end

    // Whole-line write of data and tag
    always_ff @(posedge clk) begin
        if (i_fill_en) begin
            data_mem[fill_index] <= i_fill_data;
            tag_mem[fill_index]  <= fill_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            hit_r <= 1'b0;
        end else begin
            hit_r <= i_lookup_en & lookup_match & ~fill_conflict;
        end
    end

    always_ff @(posedge clk) begin
        if (i_lookup_en) begin
            data_r <= lookup_word_data;
        end
    end

    assign o_hit  = hit_r;
    assign o_data = data_r;

endmodule

//--- hw/fetch_insn_fifo.sv
// Module fetch_insn_fifo, a flushable instruction FIFO with a registered pop stage
`include "fetch_params.svh"

module fetch_insn_fifo #(
    parameter int DEPTH = `FETCH_FIFO_DEPTH
) (
    input  logic                    clk,
    input  logic                    i_rst_n,

    input  logic                    i_flush,

    input  logic                    i_wr_en,
    input  fetch_pkg::fetch_entry_t i_wr_data,
    output logic                    o_full,

    input  logic                    i_stall,
    output logic                    o_rd_valid,
    output fetch_pkg::fetch_entry_t o_rd_data
);

    import fetch_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_entry_t     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_r;
    logic [PTR_W-1:0] rd_ptr_r;
    logic [CNT_W-1:0] count_r;
    logic             empty;
    logic             push;
    logic             pop;

    // Pointer step with wrap for any depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign empty  = (count_r == '0);
    assign o_full = (count_r == CNT_W'(DEPTH));
    assign push   = i_wr_en & ~o_full & ~i_flush;
    assign pop    = ~empty & ~i_stall & ~i_flush;

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            wr_ptr_r   <= '0;
            rd_ptr_r   <= '0;
            count_r    <= '0;
            o_rd_valid <= 1'b0;
        end else begin
            o_rd_valid <= pop;
            if (push) begin
                wr_ptr_r <= ptr_inc(wr_ptr_r);
            end
            if (pop) begin
                rd_ptr_r <= ptr_inc(rd_ptr_r);
            end
            case ({push, pop})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
        end
    end

    // Output register holds its value while the decoder stalls
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_r] <= i_wr_data;
        end
        if (pop) begin
            o_rd_data <= mem[rd_ptr_r];
        end
    end

endmodule

//--- hw/fetch_top.sv
// Module fetch_top, the fetch stage joining the FSM, PC, instruction cache and FIFO
`include "fetch_params.svh"

module fetch_top (
    input  logic                clk,
    input  logic                i_rst_n,

    // Back-end redirect
    input  logic                i_redirect,
    input  fetch_pkg::addr_t    i_redirect_addr,

    // IFQ
    input  logic                i_ifq_full,
    input  logic                i_ifq_fill_en,
    input  fetch_pkg::addr_t    i_ifq_fill_addr,
    input  fetch_pkg::ic_line_t i_ifq_fill_data,
    output logic                o_ifq_alloc_en,
    output fetch_pkg::addr_t    o_ifq_alloc_addr,

    // Decoder
    input  logic                i_decode_stall,
    output logic                o_fetch_valid,
    output fetch_pkg::addr_t    o_fetch_pc,
    output fetch_pkg::insn_t    o_fetch_insn
);

    import fetch_pkg::*;

    localparam addr_t LINE_MASK = ~addr_t'(`FETCH_IC_LINE_SIZE - 1);

    logic         ic_lookup_en;
    logic         pc_advance;
    logic         pc_restart;
    logic         fifo_wr_en;
    logic         fifo_full;
    logic         ic_hit;
    insn_t        ic_data;
    addr_t        pc;
    addr_t        lookup_pc;
    fetch_entry_t fifo_wr_data;
    fetch_entry_t fifo_rd_data;

    fetch_fsm u_fsm (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_redirect    (i_redirect),
        .i_ic_hit      (ic_hit),
        .i_fifo_full   (fifo_full),
        .i_ifq_full    (i_ifq_full),
        .i_ifq_fill_en (i_ifq_fill_en),
        .o_ic_lookup_en(ic_lookup_en),
        .o_pc_advance  (pc_advance),
        .o_pc_restart  (pc_restart),
        .o_fifo_wr_en  (fifo_wr_en),
        .o_ifq_alloc_en(o_ifq_alloc_en)
    );

    fetch_pc u_pc (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_redirect     (i_redirect),
        .i_redirect_addr(i_redirect_addr),
        .i_advance      (pc_advance),
        .i_restart      (pc_restart),
        .i_lookup_en    (ic_lookup_en),
        .o_pc           (pc),
        .o_lookup_pc    (lookup_pc)
    );

    fetch_icache u_icache (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_lookup_en  (ic_lookup_en),
        .i_lookup_addr(pc),
        .i_fill_en    (i_ifq_fill_en),
        .i_fill_addr  (i_ifq_fill_addr),
        .i_fill_data  (i_ifq_fill_data),
        .o_hit        (ic_hit),
        .o_data       (ic_data)
    );

    // Hit data paired with the PC of its lookup
    assign fifo_wr_data.pc   = lookup_pc;
    assign fifo_wr_data.insn = ic_data;

    fetch_insn_fifo u_insn_fifo (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_flush   (i_redirect),
        .i_wr_en   (fifo_wr_en),
        .i_wr_data (fifo_wr_data),
        .o_full    (fifo_full),
        .i_stall   (i_decode_stall),
        .o_rd_valid(o_fetch_valid),
        .o_rd_data (fifo_rd_data)
    );

    assign o_fetch_pc   = fifo_rd_data.pc;
    assign o_fetch_insn = fifo_rd_data.insn;

    // Missed PC stays in the lookup stage until restart
    assign o_ifq_alloc_addr = lookup_pc & LINE_MASK;

endmodule

//--- tb/tb_fetch_top.sv
// Module tb_fetch_top, a directed testbench with IFQ and memory model, LFSR, checks and tests
`include "fetch_params.svh"

module tb_fetch_top;

    import fetch_pkg::*;

    localparam int LINE_BYTES = `FETCH_IC_LINE_SIZE;
    localparam int LINE_WORDS = LINE_BYTES / (`FETCH_INSN_WIDTH / 8);

    logic     clk;
    logic     i_rst_n;
    logic     i_redirect;
    addr_t    i_redirect_addr;
    logic     i_ifq_full;
    logic     i_ifq_fill_en;
    addr_t    i_ifq_fill_addr;
    ic_line_t i_ifq_fill_data;
    logic     o_ifq_alloc_en;
    addr_t    o_ifq_alloc_addr;
    logic     i_decode_stall;
    logic     o_fetch_valid;
    addr_t    o_fetch_pc;
    insn_t    o_fetch_insn;

    int          err_value;
    int          err_timeout;
    int          err_other;
    addr_t       exp_q[$];
    addr_t       alloc_q[$];
    addr_t       exp_pc;
    logic        stall_prev;
    logic        fill_pending;
    int          fill_wait;
    addr_t       fill_addr;
    logic [15:0] lfsr_state = 16'd57122;

    fetch_top UUT (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_redirect      (i_redirect),
        .i_redirect_addr (i_redirect_addr),
        .i_ifq_full      (i_ifq_full),
        .i_ifq_fill_en   (i_ifq_fill_en),
        .i_ifq_fill_addr (i_ifq_fill_addr),
        .i_ifq_fill_data (i_ifq_fill_data),
        .o_ifq_alloc_en  (o_ifq_alloc_en),
        .o_ifq_alloc_addr(o_ifq_alloc_addr),
        .i_decode_stall  (i_decode_stall),
        .o_fetch_valid   (o_fetch_valid),
        .o_fetch_pc      (o_fetch_pc),
        .o_fetch_insn    (o_fetch_insn)
    );

    always #10 clk = ~clk;

    // Memory contents: each word is its own address with a fixed pattern
    function automatic insn_t mem_word(input addr_t addr);
        return insn_t'(addr ^ 32'h5A5A0000);
    endfunction

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] lfsr_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_step()};
        end
        return v;
    endfunction

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s: expected %h, got %h", $time, name, exp, got);
            err_value++;
        end
    endtask

    task automatic check_insn(input string name, input insn_t got, input insn_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s: expected %h, got %h", $time, name, exp, got);
            err_value++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s: expected %b, got %b", $time, name, exp, got);
            err_value++;
        end
    endtask

    // IFQ model: record each request, answer it with a whole line after 2 to 9 cycles
    always @(negedge clk) begin
        if (i_rst_n && o_ifq_alloc_en) begin
            alloc_q.push_back(o_ifq_alloc_addr);
            fill_addr    = o_ifq_alloc_addr;
            fill_wait    = 2 + int'(lfsr_bits(3));
            fill_pending = 1'b1;
        end
    end

    always @(posedge clk) begin
        #2;
        i_ifq_fill_en = 1'b0;
        if (fill_pending) begin
            fill_wait--;
            if (fill_wait == 0) begin
                fill_pending    = 1'b0;
                i_ifq_fill_en   = 1'b1;
                i_ifq_fill_addr = fill_addr;
                for (int k = 0; k < LINE_WORDS; k++) begin
                    i_ifq_fill_data[k*`FETCH_INSN_WIDTH +: `FETCH_INSN_WIDTH] =
                        mem_word(fill_addr + addr_t'(4 * k));
                end
            end
        end
    end

    // Output monitor against the expected PC queue
    always @(negedge clk) begin
        if (i_rst_n) begin
            if (stall_prev) begin
                check_bit("o_fetch_valid", o_fetch_valid, 1'b0);
            end
            if (o_fetch_valid) begin
                // Fetch keeps streaming past the last queued PC
                if (exp_q.size() == 0) begin
                    exp_q.push_back(exp_pc + addr_t'(4));
                end
                exp_pc = exp_q.pop_front();
                check_addr("o_fetch_pc", o_fetch_pc, exp_pc);
                check_insn("o_fetch_insn", o_fetch_insn, mem_word(exp_pc));
            end
        end
        stall_prev = i_decode_stall;
    end

    // Pulse a redirect, then expect count sequential PCs from addr
    task automatic redirect_to(input addr_t addr, input int count);
        @(posedge clk);
        #2;
        i_redirect      = 1'b1;
        i_redirect_addr = addr;
        @(posedge clk);
        #2;
        i_redirect = 1'b0;
        check_bit("o_fetch_valid", o_fetch_valid, 1'b0);
        exp_q.delete();
        alloc_q.delete();
        for (int k = 0; k < count; k++) begin
            exp_q.push_back(addr + addr_t'(4 * k));
        end
    endtask

    task automatic wait_outputs(input int limit, input int left);
        int n;
        n = 0;
        while (exp_q.size() > left && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() > left) begin
            $display("Timeout at t=%0t: %0d fetch outputs still missing", $time, exp_q.size());
            err_timeout++;
        end
    endtask

    task automatic wait_alloc(input int limit);
        int n;
        n = 0;
        while (alloc_q.size() == 0 && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (alloc_q.size() == 0) begin
            $display("Timeout at t=%0t: no IFQ request arrived", $time);
            err_timeout++;
        end
    endtask

    // One request per line, in line order from base
    task automatic check_line_requests(input addr_t base, input int min_count);
        if (alloc_q.size() < min_count) begin
            $display("Too few IFQ requests: expected at least %0d, saw %0d", min_count,
                     alloc_q.size());
            err_other++;
        end
        foreach (alloc_q[i]) begin
            check_addr("o_ifq_alloc_addr", alloc_q[i], base + addr_t'(LINE_BYTES * i));
        end
    endtask

    task automatic test_reset();
        i_rst_n = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #2;
            check_bit("o_fetch_valid", o_fetch_valid, 1'b0);
            check_bit("o_ifq_alloc_en", o_ifq_alloc_en, 1'b0);
        end
        i_rst_n = 1'b1;
        @(negedge clk);
        check_bit("o_fetch_valid", o_fetch_valid, 1'b0);
        check_bit("o_ifq_alloc_en", o_ifq_alloc_en, 1'b0);
    endtask

    task automatic test_cold_miss();
        redirect_to(32'h100, 24);
        wait_outputs(600, 0);
        check_line_requests(32'h100, 3);
    endtask

    task automatic test_warm_hits();
        redirect_to(32'h100, 24);
        wait_outputs(300, 0);
        foreach (alloc_q[i]) begin
            if (alloc_q[i] < 32'h160) begin
                $display("IFQ request for already cached line %h at t=%0t", alloc_q[i], $time);
                err_other++;
            end
        end
    endtask

    task automatic test_backpressure();
        int n;
        int full_cycles;
        n = 0;
        full_cycles = 0;
        redirect_to(32'h100, 64);
        while (exp_q.size() > 0 && n < 3000) begin
            @(posedge clk);
            #2;
            // Stall three cycles out of four on average
            i_decode_stall = (lfsr_bits(2) != 2'b00);
            if (UUT.fifo_full) begin
                full_cycles++;
            end
            n++;
        end
        i_decode_stall = 1'b0;
        if (exp_q.size() > 0) begin
            $display("Timeout at t=%0t: %0d stalled outputs still missing", $time, exp_q.size());
            err_timeout++;
        end
        if (full_cycles == 0) begin
            $display("Instruction FIFO never filled under decoder stalls");
            err_other++;
        end
    endtask

    task automatic test_redirect();
        redirect_to(32'h100, 64);
        wait_outputs(400, 40);
        redirect_to(32'h280, 16);
        wait_outputs(600, 0);
        check_line_requests(32'h280, 2);
    endtask

    task automatic test_ifq_full();
        @(posedge clk);
        #2;
        i_ifq_full = 1'b1;
        redirect_to(32'h380, 8);
        repeat (20) begin
            @(negedge clk);
            check_bit("o_ifq_alloc_en", o_ifq_alloc_en, 1'b0);
        end
        @(posedge clk);
        #2;
        i_ifq_full = 1'b0;
        wait_alloc(50);
        wait_outputs(300, 0);
        check_line_requests(32'h380, 1);
    endtask

    initial begin
        clk             = 1'b0;
        i_rst_n         = 1'b0;
        i_redirect      = 1'b0;
        i_redirect_addr = '0;
        i_ifq_full      = 1'b0;
        i_ifq_fill_en   = 1'b0;
        i_ifq_fill_addr = '0;
        i_ifq_fill_data = '0;
        i_decode_stall  = 1'b0;
        err_value       = 0;
        err_timeout     = 0;
        err_other       = 0;
        exp_pc          = '0;
        stall_prev      = 1'b0;
        fill_pending    = 1'b0;
        fill_wait       = 0;
        fill_addr       = '0;

        test_reset();
        test_cold_miss();
        test_warm_hits();
        test_backpressure();
        test_redirect();
        test_ifq_full();

        $display("Errors: %0d value, %0d timeout, %0d other", err_value, err_timeout, err_other);
        if (err_value + err_timeout + err_other == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
hw/fetch_pkg.sv
hw/fetch_fsm.sv
hw/fetch_pc.sv
hw/fetch_icache.sv
hw/fetch_insn_fifo.sv
hw/fetch_top.sv
tb/tb_fetch_top.sv
